// File: rv_regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register file shared types
// Index, debug address, read/write request and debug command structs,
// plus the state encoding of the debug halt sequencer
////////////////////////////////////////////////////////////////////////////

package rv_regs_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////////

  // Architectural register index, x0..x31
  typedef logic [4:0]  reg_idx_t;

  // Debug address space, low 5 bits pick a GPR
  typedef logic [11:0] dbg_addr_t;

  //////////////////////////////////////////////////////////////////////////
  // Request structs
  //////////////////////////////////////////////////////////////////////////

  // Source operand indices from decode
  typedef struct packed {
    reg_idx_t src1;
    reg_idx_t src2;
  } rd_req_t;

  // Write-back control, data travels separately (XLEN wide)
  typedef struct packed {
    logic     we;
    reg_idx_t dst;
  } wr_req_t;

  // Debug block to register file
  typedef struct packed {
    // Level, high while debug owns the file
    logic      stall;
    // Single cycle write strobe
    logic      we;
    dbg_addr_t addr;
  } dbg_cmd_t;

  //////////////////////////////////////////////////////////////////////////
  // Debug halt sequencer states
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DBG_RUN     = 2'd0,
    DBG_HALTING = 2'd1,
    DBG_HALTED  = 2'd2
  } dbg_state_t;

endpackage

// File: rv_regfile.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file
// 32 x XLEN, two read ports and one write port, x0 hard wired to zero,
// optional output register and a debug read/write path on port 1
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rv_regfile #(
  parameter int XLEN   = 32,
  parameter int REGOUT = 1
)
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Read ports
  input  rv_regs_pkg::rd_req_t  rd_req_i,
  output logic [XLEN-1:0]       rd_data1_o,
  output logic [XLEN-1:0]       rd_data2_o,

  // Write port
  input  rv_regs_pkg::wr_req_t  wr_req_i,
  input  logic [XLEN-1:0]       wr_data_i,

  // Pipeline stalls
  input  logic                  pd_stall_i,
  input  logic                  id_stall_i,

  // Debug access
  input  rv_regs_pkg::dbg_cmd_t dbg_cmd_i,
  input  logic [XLEN-1:0]       dbg_wdata_i,
  output logic [XLEN-1:0]       dbg_rdata_o
);

  //////////////////////////////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////////////////////////////

  // Storage, x0 entry exists but is masked on read
  logic [XLEN-1:0]       mem [32];

  // Captured source indices
  rv_regs_pkg::reg_idx_t src1;
  rv_regs_pkg::reg_idx_t src2;

  // Zero flags travel with the indices
  logic                  src1_is_x0;
  logic                  src2_is_x0;

  // Raw array reads
  logic [XLEN-1:0]       rfout1;
  logic [XLEN-1:0]       rfout2;

  // After x0 masking
  logic [XLEN-1:0]       dout1;
  logic [XLEN-1:0]       dout2;

  // GPR selected by the debug address
  rv_regs_pkg::reg_idx_t dbg_idx;

  // Debug stall one cycle late
  logic                  dbg_stall_dly;

  //////////////////////////////////////////////////////////////////////////
  // Debug steering
  //////////////////////////////////////////////////////////////////////////

  assign dbg_idx = dbg_cmd_i.addr[4:0];

  // Let the last pipeline index land before debug takes port 1
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dbg_stall_dly <= 1'b0;
    else
      dbg_stall_dly <= dbg_cmd_i.stall;
  end

  //////////////////////////////////////////////////////////////////////////
  // Read index registers
  //////////////////////////////////////////////////////////////////////////

  // Port 1, debug address wins once the delayed stall is up
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      src1       <= '0;
      src1_is_x0 <= 1'b1;
    end
    else if (dbg_stall_dly)
    begin
      src1       <= dbg_idx;
      src1_is_x0 <= ~|dbg_idx;
    end
    else if (!pd_stall_i)
    begin
      src1       <= rd_req_i.src1;
      src1_is_x0 <= ~|rd_req_i.src1;
    end
  end

  // Port 2, pipeline only
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      src2       <= '0;
      src2_is_x0 <= 1'b1;
    end
    else if (!pd_stall_i)
    begin
      src2       <= rd_req_i.src2;
      src2_is_x0 <= ~|rd_req_i.src2;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Array read and x0 masking
  //////////////////////////////////////////////////////////////////////////

  // Reads follow the array, so stalled reads see new writes
  assign rfout1 = mem[src1];
  assign rfout2 = mem[src2];

  assign dout1 = src1_is_x0 ? '0 : rfout1;
  assign dout2 = src2_is_x0 ? '0 : rfout2;

  // Optional output stage, frozen by the decode stall
  if (REGOUT > 0)
  begin : g_regout
    always_ff @(posedge clk_i)
    begin
      if (!id_stall_i)
      begin
        rd_data1_o <= dout1;
        rd_data2_o <= dout2;
      end
    end
  end
  else
  begin : g_comb
    assign rd_data1_o = dout1;
    assign rd_data2_o = dout2;
  end

  // Debug read word, port 1 path registered
  always_ff @(posedge clk_i)
  begin
    dbg_rdata_o <= src1_is_x0 ? '0 : rfout1;
  end

  //////////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////////

  // Debug first, a same-cycle pipeline write is dropped
  always_ff @(posedge clk_i)
  begin
    if (dbg_cmd_i.we)
      mem[dbg_idx] <= dbg_wdata_i;
    else if (wr_req_i.we)
      mem[wr_req_i.dst] <= wr_data_i;
  end

endmodule

// File: rv_dbg_regs.sv
////////////////////////////////////////////////////////////////////////////
// Debug register block
// Halt sequencer, debug address and data registers, write strobe
// and the host-side read data register for the integer register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rv_dbg_regs #(
  parameter int XLEN = 32
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Host side
  input  logic                   dbg_halt_i,
  input  logic                   dbg_wr_i,
  input  rv_regs_pkg::dbg_addr_t dbg_addr_i,
  input  logic [XLEN-1:0]        dbg_wdata_i,

  // Register file side
  output rv_regs_pkg::dbg_cmd_t  dbg_cmd_o,
  output logic [XLEN-1:0]        dbg_wdata_o,
  input  logic [XLEN-1:0]        rf_rdata_i,

  // Back to host and core
  output logic [XLEN-1:0]        dbg_rdata_o,
  output logic                   core_halted_o
);

  //////////////////////////////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////////////////////////////

  rv_regs_pkg::dbg_state_t state;
  rv_regs_pkg::dbg_state_t state_nxt;

  // Host values captured for the register file
  rv_regs_pkg::dbg_addr_t  addr_q;
  logic [XLEN-1:0]         wdata_q;
  logic                    we_q;

  // Load on a write or whenever the host moves the address
  logic                    addr_load;

  // Any non-run state stalls the core
  logic                    halted;

  //////////////////////////////////////////////////////////////////////////
  // Halt sequencer
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      rv_regs_pkg::DBG_RUN:
        if (dbg_halt_i)
          state_nxt = rv_regs_pkg::DBG_HALTING;
      // One cycle for the read path to switch over
      rv_regs_pkg::DBG_HALTING:
        if (dbg_halt_i)
          state_nxt = rv_regs_pkg::DBG_HALTED;
        else
          state_nxt = rv_regs_pkg::DBG_RUN;
      rv_regs_pkg::DBG_HALTED:
        if (!dbg_halt_i)
          state_nxt = rv_regs_pkg::DBG_RUN;
      default:
        state_nxt = rv_regs_pkg::DBG_RUN;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state <= rv_regs_pkg::DBG_RUN;
    else
      state <= state_nxt;
  end

  assign halted        = (state != rv_regs_pkg::DBG_RUN);
  assign core_halted_o = halted;

  //////////////////////////////////////////////////////////////////////////
  // Address, data and write strobe
  //////////////////////////////////////////////////////////////////////////

  assign addr_load = dbg_wr_i | (dbg_addr_i != addr_q);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      addr_q <= '0;
    else if (addr_load)
      addr_q <= dbg_addr_i;
  end

  // Data is payload only
  always_ff @(posedge clk_i)
  begin
    if (addr_load)
      wdata_q <= dbg_wdata_i;
  end

  // Host pulse becomes a single registered strobe
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      we_q <= 1'b0;
    else
      we_q <= dbg_wr_i;
  end

  assign dbg_cmd_o.stall = halted;
  assign dbg_cmd_o.we    = we_q;
  assign dbg_cmd_o.addr  = addr_q;
  assign dbg_wdata_o     = wdata_q;

  //////////////////////////////////////////////////////////////////////////
  // Read data to host
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    dbg_rdata_o <= rf_rdata_i;
  end

endmodule

// File: rv_regs_top.sv
////////////////////////////////////////////////////////////////////////////
// Register file top level
// Debug register block beside the integer register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rv_regs_top #(
  parameter int XLEN   = 32,
  parameter int REGOUT = 1
)
(
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Pipeline read/write
  input  rv_regs_pkg::rd_req_t   rd_req_i,
  input  rv_regs_pkg::wr_req_t   wr_req_i,
  input  logic [XLEN-1:0]        wr_data_i,
  input  logic                   pd_stall_i,
  input  logic                   id_stall_i,
  output logic [XLEN-1:0]        rd_data1_o,
  output logic [XLEN-1:0]        rd_data2_o,

  // Debug host
  input  logic                   dbg_halt_i,
  input  logic                   dbg_wr_i,
  input  rv_regs_pkg::dbg_addr_t dbg_addr_i,
  input  logic [XLEN-1:0]        dbg_wdata_i,
  output logic [XLEN-1:0]        dbg_rdata_o,
  output logic                   core_halted_o
);

  // Debug block to register file
  rv_regs_pkg::dbg_cmd_t dbg_cmd;
  logic [XLEN-1:0]       dbg_wdata;

  // Register file debug word back to debug block
  logic [XLEN-1:0]       rf_dbg_rdata;

  rv_dbg_regs #(
    .XLEN          (XLEN)
  ) u_dbg_regs (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dbg_halt_i    (dbg_halt_i),
    .dbg_wr_i      (dbg_wr_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_wdata_i   (dbg_wdata_i),
    .dbg_cmd_o     (dbg_cmd),
    .dbg_wdata_o   (dbg_wdata),
    .rf_rdata_i    (rf_dbg_rdata),
    .dbg_rdata_o   (dbg_rdata_o),
    .core_halted_o (core_halted_o)
  );

  rv_regfile #(
    .XLEN          (XLEN),
    .REGOUT        (REGOUT)
  ) u_regfile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rd_req_i      (rd_req_i),
    .rd_data1_o    (rd_data1_o),
    .rd_data2_o    (rd_data2_o),
    .wr_req_i      (wr_req_i),
    .wr_data_i     (wr_data_i),
    .pd_stall_i    (pd_stall_i),
    .id_stall_i    (id_stall_i),
    .dbg_cmd_i     (dbg_cmd),
    .dbg_wdata_i   (dbg_wdata),
    .dbg_rdata_o   (rf_dbg_rdata)
  );

endmodule

// File: tb_clkgen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
// 4 ns clock, synchronous reset held high for 5 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clkgen
(
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release just after the fifth rising edge
  initial
  begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: tb_rv_regs.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the register file top level
// Model array, directed and random stimulus, checks on read and debug paths
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_rv_regs;

  localparam int SEED           = 95;
  localparam int N_WRITES       = 24;
  localparam int N_READS        = 40;
  localparam int RST_LIMIT      = 20;
  localparam int HALT_EDGES     = 2;
  localparam int RELEASE_EDGES  = 1;
  localparam int DBG_READ_EDGES = 3;

  logic                   clk;
  logic                   rst;
  rv_regs_pkg::rd_req_t   rd_req;
  rv_regs_pkg::wr_req_t   wr_req;
  logic [31:0]            wr_data;
  logic                   pd_stall;
  logic                   id_stall;
  logic [31:0]            rd_data1;
  logic [31:0]            rd_data2;
  logic                   dbg_halt;
  logic                   dbg_wr;
  rv_regs_pkg::dbg_addr_t dbg_addr;
  logic [31:0]            dbg_wdata;
  logic [31:0]            dbg_rdata;
  logic                   core_halted;

  // Expected register contents
  logic [31:0]            model [32];

  tb_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  rv_regs_top #(
    .XLEN          (32),
    .REGOUT        (1)
  ) dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .rd_req_i      (rd_req),
    .wr_req_i      (wr_req),
    .wr_data_i     (wr_data),
    .pd_stall_i    (pd_stall),
    .id_stall_i    (id_stall),
    .rd_data1_o    (rd_data1),
    .rd_data2_o    (rd_data2),
    .dbg_halt_i    (dbg_halt),
    .dbg_wr_i      (dbg_wr),
    .dbg_addr_i    (dbg_addr),
    .dbg_wdata_i   (dbg_wdata),
    .dbg_rdata_o   (dbg_rdata),
    .core_halted_o (core_halted)
  );

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s (debug state %0d)", what, dut.u_dbg_regs.state);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Step to just after the next rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic pipe_write(input logic [4:0] idx, input logic [31:0] data);
    wr_req.we  = 1'b1;
    wr_req.dst = idx;
    wr_data    = data;
    tick();
    wr_req.we  = 1'b0;
    if (idx != 5'd0)
      model[idx] = data;
  endtask

  // Capture at first edge, output register at second
  task automatic read_pair(input logic [4:0] a, input logic [4:0] b);
    rd_req.src1 = a;
    rd_req.src2 = b;
    tick();
    tick();
    check_eq("rd_data1_o", rd_data1, (a == 5'd0) ? 32'd0 : model[a]);
    check_eq("rd_data2_o", rd_data2, (b == 5'd0) ? 32'd0 : model[b]);
  endtask

  // Halt level must settle within the given number of edges
  task automatic wait_halted(input logic level, input int limit);
    int n;
    n = 0;
    while (core_halted !== level && n < limit)
    begin
      tick();
      n++;
    end
    if (core_halted !== level)
      abort_run("Timeout waiting for core_halted_o to change");
  endtask

  task automatic debug_write(input logic [4:0] idx, input logic [31:0] data);
    dbg_wr    = 1'b1;
    dbg_addr  = {7'd0, idx};
    dbg_wdata = data;
    tick();
    dbg_wr    = 1'b0;
    if (idx != 5'd0)
      model[idx] = data;
  endtask

  // Poll the host read word, counted from the address register load
  task automatic wait_dbg_rdata(input logic [31:0] exp);
    int n;
    n = 0;
    while (dbg_rdata !== exp && n < DBG_READ_EDGES)
    begin
      tick();
      n++;
    end
    check_eq("dbg_rdata_o", dbg_rdata, exp);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [4:0]  hist1 [$];
    logic [4:0]  hist2 [$];
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  k;
    logic [31:0] d;
    int          n;

    void'($urandom(SEED));
    rd_req    = '0;
    wr_req    = '0;
    wr_data   = '0;
    pd_stall  = 1'b0;
    id_stall  = 1'b0;
    dbg_halt  = 1'b0;
    dbg_wr    = 1'b0;
    dbg_addr  = '0;
    dbg_wdata = '0;
    for (int i = 0; i < 32; i++)
      model[i] = 32'd0;

    n = 0;
    while (rst !== 1'b0 && n < RST_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0)
      abort_run("Timeout waiting for reset release");
    tick();

    // 1. Reset state and x0
    check_eq("core_halted_o", {31'd0, core_halted}, 32'd0);
    pipe_write(5'd0, 32'hdead_beef);
    read_pair(5'd0, 5'd0);

    // Fill all registers so nothing is undefined
    for (int i = 1; i < 32; i++)
      pipe_write(i[4:0], $urandom());

    // 2. Random writes, then back to back reads
    for (int i = 0; i < N_WRITES; i++)
    begin
      d = $urandom();
      pipe_write(d[4:0], $urandom());
    end
    for (int i = 0; i < N_READS + 2; i++)
    begin
      if (hist1.size() == 2)
      begin
        a = hist1.pop_front();
        b = hist2.pop_front();
        check_eq("rd_data1_o", rd_data1, model[a]);
        check_eq("rd_data2_o", rd_data2, model[b]);
      end
      d = $urandom();
      rd_req.src1 = d[4:0];
      rd_req.src2 = d[12:8];
      hist1.push_back(d[4:0]);
      hist2.push_back(d[12:8]);
      tick();
    end

    // 3. Index held by pd_stall, output held by id_stall
    read_pair(5'd7, 5'd9);
    pd_stall = 1'b1;
    rd_req.src1 = 5'd3;
    pipe_write(5'd7, 32'h1234_5678);
    tick();
    check_eq("rd_data1_o", rd_data1, model[7]);
    pd_stall = 1'b0;
    id_stall = 1'b1;
    rd_req.src1 = 5'd11;
    rd_req.src2 = 5'd12;
    tick();
    tick();
    check_eq("rd_data1_o", rd_data1, model[7]);
    check_eq("rd_data2_o", rd_data2, model[9]);
    id_stall = 1'b0;
    tick();
    read_pair(5'd11, 5'd12);

    // 4. Halt, debug write and read back
    dbg_halt = 1'b1;
    wait_halted(1'b1, HALT_EDGES);
    tick();
    d = $urandom();
    k = (d[4:0] == 5'd0) ? 5'd1 : d[4:0];
    debug_write(k, $urandom());
    wait_dbg_rdata(model[k]);
    dbg_addr = '0;
    // Address register loads on this edge
    tick();
    wait_dbg_rdata(32'd0);

    // 5. Debug and pipeline writes land on the same edge
    k = 5'd21;
    debug_write(k, 32'hcafe_0021);
    pipe_write(k, 32'h0bad_0021);
    model[k] = 32'hcafe_0021;
    wait_dbg_rdata(model[k]);
    dbg_halt = 1'b0;
    wait_halted(1'b0, RELEASE_EDGES);
    tick();
    tick();
    read_pair(k, 5'd7);
    read_pair(5'd11, k);

    $display("Verification passed");
    $finish;
  end

endmodule

// File: project.f
rv_regs_pkg.sv
rv_regfile.sv
rv_dbg_regs.sv
rv_regs_top.sv
tb_clkgen.sv
tb_rv_regs.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module tb_rv_regs \
  -o sim_tb_rv_regs > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb_rv_regs > "$LOG" 2>&1
cat "$LOG"

grep -q "Verification failed" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" "$LOG" || { echo "Simulation did not finish"; exit 1; }
echo "Simulation PASSED"
exit 0
